//--- hw/nes_bus_pkg.sv
`default_nettype none

package nes_bus_pkg;

	// 6502 bus widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	// Work RAM, 2 KB mirrored four times below 0x2000
	localparam int RAM_DEPTH = 2048;
	localparam int RAM_ADDR_W = $clog2(RAM_DEPTH);
	localparam logic [ADDR_W-1:0] RAM_MIRROR_END = 16'h1FFF;

	localparam logic [ADDR_W-1:0] JOY1_ADDR = 16'h4016; // Player 1 pad
	localparam logic [ADDR_W-1:0] JOY2_ADDR = 16'h4017; // Player 2 pad

	// Value seen on reads of unmapped space
	localparam logic [DATA_W-1:0] OPEN_BUS_DATA = 8'h00;

endpackage

`default_nettype wire

//--- hw/sys_ctrl_pkg.sv
`default_nettype none

package sys_ctrl_pkg;

	localparam int CLKS_PER_BIT = 16; // One UART bit period
	localparam int BAUD_CNT_W = $clog2(CLKS_PER_BIT);

	// Reply queue in the transmitter, also the starting credit count
	localparam int TX_QUEUE_DEPTH = 4;
	localparam int QPTR_W = $clog2(TX_QUEUE_DEPTH);
	localparam int CREDIT_W = $clog2(TX_QUEUE_DEPTH + 1);

	typedef enum logic [7:0] {
		CMD_WRITE = 8'h01, // op, addr hi, addr lo, data
		CMD_READ  = 8'h02, // op, addr hi, addr lo
		CMD_HALT  = 8'h03,
		CMD_RUN   = 8'h04
	} cmd_op_t;

	localparam logic [7:0] REPLY_ACK = 8'hAA;
	localparam logic [7:0] REPLY_NAK = 8'hEE;

	typedef enum logic [2:0] {
		IDLE, GET_ADDR_HI, GET_ADDR_LO, GET_DATA,
		MEM_WRITE, MEM_READ, MEM_WAIT, SEND_REPLY
	} sys_state_t;

endpackage

`default_nettype wire

//--- hw/mem_bus_if.sv
`default_nettype none
`timescale 1ns/100ps

interface mem_bus_if;
	import nes_bus_pkg::*;

	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata; // Valid the cycle after re
	logic we;
	logic re;

	// System controller side
	modport master (output addr, wdata, we, re, input rdata);

	// Memory controller side
	modport slave (input addr, wdata, we, re, output rdata);

endinterface

`default_nettype wire

//--- hw/baud_timer.sv
`default_nettype none
`timescale 1ns/100ps

module baud_timer (
	input  wire  clk,
	input  wire  rst,
	input  wire  run,
	output logic mid_tick,
	output logic bit_tick
);
	import sys_ctrl_pkg::*;

	logic [BAUD_CNT_W-1:0] cnt;

	// Count held at zero while idle so each frame starts aligned
	always_ff @(posedge clk) begin
		if (rst || !run) begin
			cnt <= '0;
		end else if (cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	assign mid_tick = run && (cnt == BAUD_CNT_W'(CLKS_PER_BIT / 2 - 1)); // Half period
	assign bit_tick = run && (cnt == BAUD_CNT_W'(CLKS_PER_BIT - 1)); // End of bit

endmodule

`default_nettype wire

//--- hw/uart_rx.sv
`default_nettype none
`timescale 1ns/100ps

module uart_rx (
	input  wire        clk,
	input  wire        rst,
	input  wire        uart_rx,
	output logic [7:0] rx_data,
	output logic       rx_valid
);
	typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_t;

	rx_state_t state;
	logic rx_meta;
	logic rx_sync;
	logic [2:0] bit_cnt;
	logic mid_tick;

	baud_timer baud_timer_inst (
		.clk      (clk),
		.rst      (rst),
		.run      (state != RX_IDLE),
		.mid_tick (mid_tick),
		.bit_tick ()
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= RX_IDLE;
			rx_meta  <= 1'b1;
			rx_sync  <= 1'b1;
			bit_cnt  <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_meta  <= uart_rx; // Two flop synchronizer
			rx_sync  <= rx_meta;
			rx_valid <= 1'b0;
			case (state)
				RX_IDLE: begin
					if (!rx_sync) state <= RX_START; // Falling start edge
				end
				RX_START: begin
					if (mid_tick) begin
						// A glitch shorter than half a bit is not a start bit
						state   <= rx_sync ? RX_IDLE : RX_DATA;
						bit_cnt <= '0;
					end
				end
				RX_DATA: begin
					if (mid_tick) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7) state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (mid_tick) begin
						rx_valid <= rx_sync; // Low stop bit is a framing error
						state    <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// LSB first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && mid_tick) rx_data <= {rx_sync, rx_data[7:1]};
	end

endmodule

`default_nettype wire

//--- hw/uart_tx.sv
`default_nettype none
`timescale 1ns/100ps

module uart_tx (
	input  wire       clk,
	input  wire       rst,
	input  wire [7:0] tx_data,
	input  wire       tx_push,
	output logic      tx_credit,
	input  wire       uart_rts,
	output logic      uart_tx
);
	import sys_ctrl_pkg::*;

	logic [7:0] queue [TX_QUEUE_DEPTH];
	logic [QPTR_W-1:0] wr_ptr, rd_ptr;
	logic [CREDIT_W-1:0] q_count;
	logic q_full, q_empty, pop, busy, bit_tick;
	logic [8:0] shift; // Data bits then stop bit
	logic [3:0] bit_idx;

	baud_timer baud_timer_inst (
		.clk      (clk),
		.rst      (rst),
		.run      (busy),
		.mid_tick (),
		.bit_tick (bit_tick)
	);

	assign q_empty = (q_count == '0);
	assign q_full = (q_count == CREDIT_W'(TX_QUEUE_DEPTH));
	assign pop = !busy && !q_empty && uart_rts; // Only between frames
	assign tx_credit = pop; // Slot freed as the byte leaves the queue

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			q_count <= '0;
			busy    <= 1'b0;
			bit_idx <= '0;
			uart_tx <= 1'b1; // Line idles high
		end else begin
			if (tx_push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
			case ({tx_push, pop})
				2'b10:   q_count <= q_count + 1'b1;
				2'b01:   q_count <= q_count - 1'b1;
				default: q_count <= q_count;
			endcase

			if (pop) begin
				busy    <= 1'b1;
				bit_idx <= '0;
				uart_tx <= 1'b0; // Start bit
			end else if (busy && bit_tick) begin
				if (bit_idx == 4'd9) begin
					busy    <= 1'b0; // Stop bit done
					uart_tx <= 1'b1;
				end else begin
					uart_tx <= shift[0];
					bit_idx <= bit_idx + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tx_push) queue[wr_ptr] <= tx_data;
		if (pop) begin
			shift <= {1'b1, queue[rd_ptr]};
		end else if (busy && bit_tick) begin
			shift <= {1'b1, shift[8:1]};
		end
	end

	// The sender's credit count must keep it from overrunning the queue
	a_no_push_when_full: assert property (@(posedge clk) disable iff (rst)
		tx_push |-> !q_full)
		else $error("uart_tx: push into a full queue");

endmodule

`default_nettype wire

//--- hw/sys_ctrl_fsm.sv
`default_nettype none
`timescale 1ns/100ps

module sys_ctrl_fsm (
	input  wire        clk,
	input  wire        rst,
	input  wire  [7:0] rx_data,
	input  wire        rx_valid,
	output logic [7:0] tx_data,
	output logic       tx_push,
	input  wire        tx_credit,
	mem_bus_if.master  mem,
	output logic       cpu_halt,
	output logic [nes_bus_pkg::ADDR_W-1:0] sys_addr
);
	import nes_bus_pkg::*;
	import sys_ctrl_pkg::*;

	sys_state_t state;
	cmd_op_t op;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [CREDIT_W-1:0] credits; // Free slots in the transmit queue

	assign mem.addr = addr;
	assign mem.wdata = wdata;
	assign mem.we = (state == MEM_WRITE);
	assign mem.re = (state == MEM_READ);
	assign tx_push = (state == SEND_REPLY) && (credits != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			credits <= CREDIT_W'(TX_QUEUE_DEPTH);
		end else begin
			case ({tx_credit, tx_push})
				2'b10:   credits <= credits + 1'b1;
				2'b01:   credits <= credits - 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state    <= IDLE;
			cpu_halt <= 1'b0;
			sys_addr <= '0;
		end else begin
			case (state)
				IDLE: begin
					if (rx_valid) begin
						case (rx_data)
							CMD_WRITE, CMD_READ: state <= GET_ADDR_HI;
							CMD_HALT: begin
								cpu_halt <= 1'b1;
								state    <= SEND_REPLY;
							end
							CMD_RUN: begin
								cpu_halt <= 1'b0;
								state    <= SEND_REPLY;
							end
							default: state <= SEND_REPLY; // Unknown opcode
						endcase
					end
				end
				GET_ADDR_HI: if (rx_valid) state <= GET_ADDR_LO;
				GET_ADDR_LO: begin
					if (rx_valid) begin
						if (op == CMD_WRITE) state <= GET_DATA;
						else state <= cpu_halt ? MEM_READ : SEND_REPLY;
					end
				end
				GET_DATA: if (rx_valid) state <= cpu_halt ? MEM_WRITE : SEND_REPLY;
				MEM_WRITE: begin
					sys_addr <= addr;
					state    <= SEND_REPLY;
				end
				MEM_READ: begin
					sys_addr <= addr;
					state    <= MEM_WAIT;
				end
				MEM_WAIT: state <= SEND_REPLY; // rdata lands this cycle
				SEND_REPLY: if (credits != '0) state <= IDLE; // Wait for a free slot
				default: state <= IDLE;
			endcase
		end
	end

	// Command fields and the reply byte
	always_ff @(posedge clk) begin
		case (state)
			IDLE: begin
				if (rx_valid) begin
					op      <= cmd_op_t'(rx_data);
					tx_data <= (rx_data == CMD_HALT || rx_data == CMD_RUN) ?
						REPLY_ACK : REPLY_NAK;
				end
			end
			GET_ADDR_HI: if (rx_valid) addr[ADDR_W-1:8] <= rx_data;
			GET_ADDR_LO: begin
				if (rx_valid) begin
					addr[7:0] <= rx_data;
					tx_data   <= REPLY_NAK; // Kept only if the CPU is running
				end
			end
			GET_DATA: begin
				if (rx_valid) begin
					wdata   <= rx_data;
					tx_data <= REPLY_NAK;
				end
			end
			MEM_WRITE: tx_data <= REPLY_ACK;
			MEM_WAIT: tx_data <= mem.rdata;
			default: ;
		endcase
	end

	// Credits come back only for bytes actually pushed
	a_credit_bound: assert property (@(posedge clk) disable iff (rst)
		credits <= CREDIT_W'(TX_QUEUE_DEPTH))
		else $error("sys_ctrl_fsm: credit count above queue depth");

	a_single_access: assert property (@(posedge clk) disable iff (rst)
		(mem.we || mem.re) |-> !(mem.we && mem.re) ##1 !(mem.we || mem.re))
		else $error("sys_ctrl_fsm: overlapping or stretched memory access");

endmodule

`default_nettype wire

//--- hw/mem_ctrl.sv
`default_nettype none
`timescale 1ns/100ps

module mem_ctrl (
	input  wire       clk,
	input  wire       rst,
	mem_bus_if.slave  mem,
	input  wire       cpu_halt,
	input  wire [nes_bus_pkg::ADDR_W-1:0] cpu_addr,
	input  wire [nes_bus_pkg::DATA_W-1:0] cpu_wdata,
	input  wire       cpu_we,
	input  wire       cpu_re,
	output logic [nes_bus_pkg::DATA_W-1:0] cpu_rdata,
	input  wire [nes_bus_pkg::DATA_W-1:0] joycon_1,
	input  wire [nes_bus_pkg::DATA_W-1:0] joycon_2
);
	import nes_bus_pkg::*;

	logic [DATA_W-1:0] ram [RAM_DEPTH];
	logic [ADDR_W-1:0] bus_addr;
	logic [DATA_W-1:0] bus_wdata, rd_mux, rd_q, joy1_q, joy2_q;
	logic bus_we, bus_re, is_ram, ram_we;
	logic rd_sys; // Read data belongs to the system side

	// Halted CPU hands the bus to the system controller
	assign bus_addr = cpu_halt ? mem.addr : cpu_addr;
	assign bus_wdata = cpu_halt ? mem.wdata : cpu_wdata;
	assign bus_we = cpu_halt ? mem.we : cpu_we;
	assign bus_re = cpu_halt ? mem.re : cpu_re;

	assign is_ram = (bus_addr <= RAM_MIRROR_END);
	assign ram_we = bus_we && is_ram; // Writes elsewhere are dropped

	always_comb begin
		if (is_ram) rd_mux = ram[bus_addr[RAM_ADDR_W-1:0]]; // Mirrors fold onto 2 KB
		else if (bus_addr == JOY1_ADDR) rd_mux = joy1_q;
		else if (bus_addr == JOY2_ADDR) rd_mux = joy2_q;
		else rd_mux = OPEN_BUS_DATA;
	end

	always_ff @(posedge clk) begin
		joy1_q <= joycon_1; // Pad inputs sampled every clock
		joy2_q <= joycon_2;
		if (ram_we) ram[bus_addr[RAM_ADDR_W-1:0]] <= bus_wdata;
		if (bus_re) rd_q <= rd_mux;
	end

	always_ff @(posedge clk) begin
		if (rst) rd_sys <= 1'b0;
		else rd_sys <= cpu_halt;
	end

	assign mem.rdata = rd_sys ? rd_q : OPEN_BUS_DATA;
	assign cpu_rdata = rd_sys ? OPEN_BUS_DATA : rd_q;

	a_no_cpu_write_halted: assert property (@(posedge clk) disable iff (rst)
		(cpu_halt && cpu_we && !mem.we) |-> !ram_we)
		else $error("mem_ctrl: CPU write reached RAM while halted");

endmodule

`default_nettype wire

//--- hw/nes_sys_top.sv
`default_nettype none
`timescale 1ns/100ps

module nes_sys_top (
	input  wire clk,
	input  wire rst,

	input  wire uart_rx,
	input  wire uart_rts, // Host ready for reply bytes
	output wire uart_tx,

	// Bus port standing in for the 6502
	input  wire [nes_bus_pkg::ADDR_W-1:0] cpu_addr,
	input  wire [nes_bus_pkg::DATA_W-1:0] cpu_wdata,
	input  wire cpu_we,
	input  wire cpu_re,
	output wire [nes_bus_pkg::DATA_W-1:0] cpu_rdata,

	input  wire [nes_bus_pkg::DATA_W-1:0] joycon_1, // Bit order as on the pad
	input  wire [nes_bus_pkg::DATA_W-1:0] joycon_2,

	output wire cpu_halt,
	output wire [nes_bus_pkg::ADDR_W-1:0] sys_addr
);
	logic [7:0] rx_data, tx_data;
	logic rx_valid, tx_push, tx_credit;

	mem_bus_if sys_bus ();

	uart_rx uart_rx_inst (
		.clk      (clk),
		.rst      (rst),
		.uart_rx  (uart_rx),
		.rx_data  (rx_data),
		.rx_valid (rx_valid)
	);

	uart_tx uart_tx_inst (
		.clk       (clk),
		.rst       (rst),
		.tx_data   (tx_data),
		.tx_push   (tx_push),
		.tx_credit (tx_credit),
		.uart_rts  (uart_rts),
		.uart_tx   (uart_tx)
	);

	sys_ctrl_fsm sys_ctrl_inst (
		.clk       (clk),
		.rst       (rst),
		.rx_data   (rx_data),
		.rx_valid  (rx_valid),
		.tx_data   (tx_data),
		.tx_push   (tx_push),
		.tx_credit (tx_credit),
		.mem       (sys_bus.master),
		.cpu_halt  (cpu_halt),
		.sys_addr  (sys_addr)
	);

	mem_ctrl mem_ctrl_inst (
		.clk       (clk),
		.rst       (rst),
		.mem       (sys_bus.slave),
		.cpu_halt  (cpu_halt), // Owner select
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_we    (cpu_we),
		.cpu_re    (cpu_re),
		.cpu_rdata (cpu_rdata),
		.joycon_1  (joycon_1),
		.joycon_2  (joycon_2)
	);

endmodule

`default_nettype wire

//--- tb/tb_nes_sys.sv
`default_nettype none
`timescale 1ns/100ps

module tb_nes_sys;
	import nes_bus_pkg::*;
	import sys_ctrl_pkg::*;

	localparam int FRAME_CLKS = 10 * CLKS_PER_BIT;
	localparam int EST_FRAMES = 300; // Commands and replies over all tests
	localparam int BP_CLKS = 2000; // Back-pressure hold time
	localparam int MAX_CYCLES = 4 * (EST_FRAMES * FRAME_CLKS + BP_CLKS);

	logic clk, rst, uart_rx, uart_rts, uart_tx;
	logic cpu_we, cpu_re, cpu_halt;
	logic [ADDR_W-1:0] cpu_addr, sys_addr;
	logic [DATA_W-1:0] cpu_wdata, cpu_rdata, joycon_1, joycon_2;

	logic [7:0] ram_model [RAM_DEPTH];
	logic [7:0] exp_q [$]; // Replies the host still waits for
	logic [15:0] addr_list [16];
	logic [31:0] rng_state = 32'h521bd42c;
	int cycle_cnt = 0;
	int errors = 0;
	int checks = 0;
	int test_errs = 0;
	int test_num = 0;
	int tests_ok = 0;
	string test_name;

	nes_sys_top dut0 (
		.clk       (clk),
		.rst       (rst),
		.uart_rx   (uart_rx),
		.uart_rts  (uart_rts),
		.uart_tx   (uart_tx),
		.cpu_addr  (cpu_addr),
		.cpu_wdata (cpu_wdata),
		.cpu_we    (cpu_we),
		.cpu_re    (cpu_re),
		.cpu_rdata (cpu_rdata),
		.joycon_1  (joycon_1),
		.joycon_2  (joycon_2),
		.cpu_halt  (cpu_halt),
		.sys_addr  (sys_addr)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_cnt++;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("TEST FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	// Expected read value from the NES CPU map
	function automatic logic [7:0] expected_read(input logic [15:0] addr);
		logic [RAM_ADDR_W-1:0] idx;
		idx = RAM_ADDR_W'(addr % RAM_DEPTH);
		if (addr <= 16'h1FFF) return ram_model[idx];
		if (addr == 16'h4016) return joycon_1;
		if (addr == 16'h4017) return joycon_2;
		return 8'h00;
	endfunction

	task automatic model_write(input logic [15:0] addr, input logic [7:0] data);
		if (addr <= 16'h1FFF) ram_model[RAM_ADDR_W'(addr % RAM_DEPTH)] = data;
	endtask

	// Ends 1 ns after a rising edge
	task automatic step(input int n);
		repeat (n) @(posedge clk);
		#1;
	endtask

	task automatic report_mismatch(input string what, input logic [7:0] got,
			input logic [7:0] exp);
		$display("ERROR @%0t: %s got %02h, expected %02h", $time, what, got, exp);
		errors++;
	endtask

	task automatic uart_send(input logic [7:0] b);
		logic [9:0] frame;
		frame = {1'b1, b, 1'b0}; // Stop, data LSB first, start
		for (int i = 0; i < 10; i++) begin
			uart_rx = frame[i];
			step(CLKS_PER_BIT);
		end
	endtask

	task automatic wait_reply();
		while (exp_q.size() != 0) @(posedge clk);
		step(CLKS_PER_BIT / 2 - 1); // Up to the end of the stop bit
	endtask

	task automatic host_cmd(input logic [7:0] op, input logic [7:0] exp);
		exp_q.push_back(exp);
		uart_send(op);
		wait_reply();
	endtask

	task automatic host_write(input logic [15:0] addr, input logic [7:0] data,
			input logic [7:0] exp);
		exp_q.push_back(exp);
		uart_send(CMD_WRITE);
		uart_send(addr[15:8]);
		uart_send(addr[7:0]);
		uart_send(data);
		wait_reply();
	endtask

	task automatic host_read_start(input logic [15:0] addr, input logic [7:0] exp);
		exp_q.push_back(exp);
		uart_send(CMD_READ);
		uart_send(addr[15:8]);
		uart_send(addr[7:0]);
	endtask

	task automatic host_read(input logic [15:0] addr, input logic [7:0] exp);
		host_read_start(addr, exp);
		wait_reply();
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_addr = addr;
		cpu_wdata = data;
		cpu_we = 1'b1;
		step(1);
		cpu_we = 1'b0;
	endtask

	task automatic cpu_read_check(input logic [15:0] addr, input logic [7:0] exp);
		cpu_addr = addr;
		cpu_re = 1'b1;
		step(1);
		cpu_re = 1'b0;
		checks++;
		if (cpu_rdata !== exp) report_mismatch("cpu_rdata", cpu_rdata, exp);
	endtask

	task automatic check_halt(input logic exp);
		step(5);
		checks++;
		if (cpu_halt !== exp) begin
			$display("ERROR @%0t: cpu_halt is %b, expected %b", $time, cpu_halt, exp);
			errors++;
		end
	endtask

	task automatic test_begin(input string name);
		test_name = name;
		test_errs = errors;
		test_num++;
	endtask

	task automatic test_end();
		if (errors == test_errs) begin
			tests_ok++;
			$display("Test %0d %s: passed", test_num, test_name);
		end else begin
			$display("Test %0d %s: failed, %0d errors", test_num, test_name,
				errors - test_errs);
		end
	endtask

	// Host receiver, compares every reply frame against the queue
	initial begin : reply_compare
		logic [7:0] got;
		logic [7:0] exp;
		forever begin
			@(negedge clk);
			if (uart_tx === 1'b0) begin
				repeat (CLKS_PER_BIT / 2) @(negedge clk); // Middle of start bit
				for (int i = 0; i < 8; i++) begin
					repeat (CLKS_PER_BIT) @(negedge clk);
					got[i] = uart_tx;
				end
				repeat (CLKS_PER_BIT) @(negedge clk);
				checks++;
				if (uart_tx !== 1'b1) begin
					$display("Framing error: stop bit of reply %02h is low at %0t", got, $time);
					errors++;
				end
				if (exp_q.size() == 0) begin
					$display("Unexpected reply byte %02h on uart_tx at %0t", got, $time);
					errors++;
				end else begin
					exp = exp_q.pop_front();
					checks++;
					if (got !== exp) report_mismatch("reply byte", got, exp);
				end
			end
		end
	end

	initial begin : stimulus
		logic [31:0] r;
		logic [15:0] a;
		int low_cnt;
		rst = 1'b1;
		uart_rx = 1'b1;
		uart_rts = 1'b1;
		cpu_addr = '0;
		cpu_wdata = '0;
		cpu_we = 1'b0;
		cpu_re = 1'b0;
		joycon_1 = 8'h00;
		joycon_2 = 8'h00;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		step(4);

		test_begin("halt_run_opcodes");
		host_cmd(CMD_HALT, REPLY_ACK);
		check_halt(1'b1);
		host_cmd(CMD_RUN, REPLY_ACK);
		check_halt(1'b0);
		host_cmd(8'h5A, REPLY_NAK); // Not an opcode
		check_halt(1'b0);
		test_end();

		test_begin("uart_write_read");
		host_cmd(CMD_HALT, REPLY_ACK);
		for (int i = 0; i < 16; i++) begin
			r = next_rand();
			addr_list[i] = r[15:0] % 16'h1800; // Room for the +0x0800 mirror
			model_write(addr_list[i], r[23:16]);
			host_write(addr_list[i], r[23:16], REPLY_ACK);
		end
		for (int i = 0; i < 16; i++) begin
			host_read(addr_list[i], expected_read(addr_list[i]));
			checks++;
			if (sys_addr !== addr_list[i]) begin
				$display("ERROR @%0t: sys_addr %04h, expected %04h", $time, sys_addr,
					addr_list[i]);
				errors++;
			end
			host_read(addr_list[i] + 16'h0800, expected_read(addr_list[i] + 16'h0800));
		end
		test_end();

		test_begin("uart_access_running");
		host_cmd(CMD_RUN, REPLY_ACK);
		a = addr_list[0];
		host_write(a, ~expected_read(a), REPLY_NAK);
		host_read(a, REPLY_NAK);
		cpu_read_check(a, expected_read(a)); // Still the old value
		test_end();

		test_begin("cpu_port");
		for (int i = 0; i < 8; i++) begin
			r = next_rand();
			addr_list[i] = {3'b000, r[12:0]};
			model_write(addr_list[i], r[31:24]);
			cpu_write(addr_list[i], r[31:24]);
		end
		for (int i = 0; i < 8; i++) cpu_read_check(addr_list[i], expected_read(addr_list[i]));
		host_cmd(CMD_HALT, REPLY_ACK);
		a = addr_list[1];
		cpu_read_check(a, 8'h00);
		cpu_write(a, ~expected_read(a)); // Dropped while halted
		host_read(a, expected_read(a));
		host_cmd(CMD_RUN, REPLY_ACK);
		cpu_read_check(a, expected_read(a));
		test_end();

		test_begin("joypad_unmapped");
		r = next_rand();
		joycon_1 = r[7:0];
		joycon_2 = r[15:8];
		step(2);
		cpu_read_check(16'h4016, expected_read(16'h4016));
		cpu_read_check(16'h4017, expected_read(16'h4017));
		cpu_read_check(16'h5000, expected_read(16'h5000));
		host_cmd(CMD_HALT, REPLY_ACK);
		host_read(16'h4016, expected_read(16'h4016));
		host_read(16'h4017, expected_read(16'h4017));
		host_read(16'h2000, expected_read(16'h2000)); // Just past the mirrors
		test_end();

		test_begin("rts_backpressure");
		a = addr_list[2];
		uart_rts = 1'b0;
		host_read_start(a, expected_read(a));
		low_cnt = 0;
		for (int i = 0; i < BP_CLKS; i++) begin
			if (uart_tx !== 1'b1) low_cnt++;
			step(1);
		end
		checks++;
		if (low_cnt != 0) begin
			$display("uart_tx left idle for %0d cycles while uart_rts was low", low_cnt);
			errors++;
		end
		uart_rts = 1'b1;
		wait_reply();
		test_end();

		$display("Summary: %0d of %0d tests passed, %0d checks, %0d errors",
			tests_ok, test_num, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hw/nes_bus_pkg.sv
hw/sys_ctrl_pkg.sv
hw/mem_bus_if.sv
hw/baud_timer.sv
hw/uart_rx.sv
hw/uart_tx.sv
hw/sys_ctrl_fsm.sv
hw/mem_ctrl.sv
hw/nes_sys_top.sv
tb/tb_nes_sys.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then search the log
set -u
cd "$(dirname "$0")" || exit 1

TOP=tb_nes_sys
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/100ps \
	-f verilog.f --top-module "$TOP" -o "sim_$TOP"
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

"./obj_dir/sim_$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	exit 1
fi
exit 0
